// File: hdl/aesMixPkg.sv
`default_nettype none

package aesMixPkg;

  // ====================================================================
  // sizes
  // ====================================================================
  localparam int stateWidth  = 128;
  localparam int columnWidth = 32;
  localparam int numColumns  = 4;
  localparam int colIdxWidth = $clog2(numColumns);  // column counter width

  // ====================================================================
  // types
  // ====================================================================
  typedef enum logic {
    mixForward,  // MixColumns, then key
    mixInverse   // key, then InvMixColumns
  } mixDir_t;

  typedef enum logic [1:0] {
    seqIdle,
    seqColumns,
    seqFinish
  } seqState_t;

  typedef struct packed {
    mixDir_t                dir;
    logic [stateWidth-1:0]  state;     // column 0 in the top bits
    logic [stateWidth-1:0]  roundKey;
  } mixRequest_t;

  // ====================================================================
  // GF(2^8) helpers
  // ====================================================================

  // multiply by 2 modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] xtime(input logic [7:0] b);
    logic [7:0] shifted;
    shifted = {b[6:0], 1'b0};
    return b[7] ? (shifted ^ 8'h1b) : shifted;  // fold the carry back in
  endfunction

endpackage

`default_nettype wire

// File: hdl/mixColumnHelper.sv
`timescale 1ns/1ps
`default_nettype none

module mixColumnHelper (
  input  wire logic [aesMixPkg::columnWidth-1:0] column,
  input  wire aesMixPkg::mixDir_t                dir,
  output logic [aesMixPkg::columnWidth-1:0]      mixed
);

  logic [0:aesMixPkg::numColumns-1][7:0] colBytes;  // byte 0 = bits 31:24
  logic [0:aesMixPkg::numColumns-1][7:0] fwdBytes;
  logic [0:aesMixPkg::numColumns-1][7:0] invBytes;

  function automatic logic [7:0] mul3(input logic [7:0] b);
    return aesMixPkg::xtime(b) ^ b;
  endfunction

  // x8 built once, the inverse coefficients share it
  function automatic logic [7:0] mulInv(input logic [7:0] b, input logic [3:0] coeff);
    logic [7:0] x2;
    logic [7:0] x4;
    logic [7:0] x8;
    x2 = aesMixPkg::xtime(b);
    x4 = aesMixPkg::xtime(x2);
    x8 = aesMixPkg::xtime(x4);
    return x8 ^ (coeff[2] ? x4 : 8'h00) ^ (coeff[1] ? x2 : 8'h00) ^ (coeff[0] ? b : 8'h00);
  endfunction

  assign colBytes = column;

  always_comb begin
    for (int i = 0; i < aesMixPkg::numColumns; i++) begin
      fwdBytes[i] = aesMixPkg::xtime(colBytes[i])
                  ^ mul3(colBytes[(i + 1) % aesMixPkg::numColumns])
                  ^ colBytes[(i + 2) % aesMixPkg::numColumns]
                  ^ colBytes[(i + 3) % aesMixPkg::numColumns];  // 02 03 01 01
      invBytes[i] = mulInv(colBytes[i], 4'he)
                  ^ mulInv(colBytes[(i + 1) % aesMixPkg::numColumns], 4'hb)
                  ^ mulInv(colBytes[(i + 2) % aesMixPkg::numColumns], 4'hd)
                  ^ mulInv(colBytes[(i + 3) % aesMixPkg::numColumns], 4'h9);  // 0e 0b 0d 09
    end
  end

  assign mixed = (dir == aesMixPkg::mixInverse) ? invBytes : fwdBytes;

endmodule

`default_nettype wire

// File: hdl/columnSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module columnSequencer (
  input  wire logic                              clk,
  input  wire logic                              reset,
  input  wire logic                              start,
  input  wire aesMixPkg::mixRequest_t            request,
  input  wire logic [aesMixPkg::columnWidth-1:0] mixed,
  output logic [aesMixPkg::columnWidth-1:0]      column,
  output aesMixPkg::mixDir_t                     dir,
  output logic                                   busy,
  output logic                                   done,
  output logic [aesMixPkg::stateWidth-1:0]       result
);

  aesMixPkg::seqState_t                     state;
  logic [aesMixPkg::colIdxWidth-1:0]        colIdx;
  logic                                     accept;
  logic                                     lastCol;
  logic [0:aesMixPkg::numColumns-1][aesMixPkg::columnWidth-1:0] workState;
  logic [0:aesMixPkg::numColumns-1][aesMixPkg::columnWidth-1:0] mixedState;
  logic [aesMixPkg::stateWidth-1:0]         keyReg;
  logic [aesMixPkg::stateWidth-1:0]         finalState;

  assign busy    = (state == aesMixPkg::seqColumns);
  assign done    = (state == aesMixPkg::seqFinish);
  assign accept  = start && !busy;  // starts while busy are dropped
  assign lastCol = (colIdx == aesMixPkg::colIdxWidth'(aesMixPkg::numColumns - 1));

  assign column = workState[colIdx];

  // ====================================================================
  // result of the last column
  // ====================================================================
  always_comb begin
    mixedState = workState;
    mixedState[aesMixPkg::numColumns-1] = mixed;
    if (dir == aesMixPkg::mixForward) begin
      finalState = mixedState ^ keyReg;  // key goes after the mix
    end else begin
      finalState = mixedState;
    end
  end

  // ====================================================================
  // control
  // ====================================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= aesMixPkg::seqIdle;
      colIdx <= '0;
      result <= '0;
    end else begin
      case (state)
        aesMixPkg::seqIdle, aesMixPkg::seqFinish: begin
          if (accept) begin
            state  <= aesMixPkg::seqColumns;
            colIdx <= '0;
          end else begin
            state <= aesMixPkg::seqIdle;
          end
        end
        aesMixPkg::seqColumns: begin
          colIdx <= colIdx + 1'b1;  // wraps back to 0 after column 3
          if (lastCol) begin
            state  <= aesMixPkg::seqFinish;
            result <= finalState;
          end
        end
        default: state <= aesMixPkg::seqIdle;
      endcase
    end
  end

  // working state, key and direction
  always_ff @(posedge clk) begin
    if (accept) begin
      dir    <= request.dir;
      keyReg <= request.roundKey;
      if (request.dir == aesMixPkg::mixInverse) begin
        workState <= request.state ^ request.roundKey;  // inverse adds key first
      end else begin
        workState <= request.state;
      end
    end else if (busy) begin
      workState[colIdx] <= mixed;
    end
  end

  // ====================================================================
  // checks
  // ====================================================================
  doneSinglePulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done held for more than one cycle");

  idleQuiet: assert property (@(posedge clk) disable iff (reset)
    (state == aesMixPkg::seqIdle && !start) |=> !(busy || done))
    else $error("busy or done raised without an accepted start");

  columnsStartAtZero: assert property (@(posedge clk) disable iff (reset)
    (state == aesMixPkg::seqColumns && $past(state) != aesMixPkg::seqColumns)
      |-> (colIdx == '0))
    else $error("column walk did not start at column 0");

endmodule

`default_nettype wire

// File: hdl/mixRound.sv
`timescale 1ns/1ps
`default_nettype none

module mixRound (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        start,
  input  wire aesMixPkg::mixRequest_t      request,
  output logic                             busy,
  output logic                             done,
  output logic [aesMixPkg::stateWidth-1:0] result
);

  logic [aesMixPkg::columnWidth-1:0] column;  // sequencer to mixer
  logic [aesMixPkg::columnWidth-1:0] mixed;   // mixer back, same cycle
  aesMixPkg::mixDir_t                dir;

  columnSequencer i_columnSequencer (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .request (request),
    .mixed   (mixed),
    .column  (column),
    .dir     (dir),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  // one shared mixer, used once per column
  mixColumnHelper i_mixColumnHelper (
    .column (column),
    .dir    (dir),
    .mixed  (mixed)
  );

endmodule

`default_nettype wire

// File: tb/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

module tbClockGen (
  output logic clk,
  output logic reset
);

  localparam time halfPeriod  = 10;  // 20 ns clock
  localparam int  resetCycles = 5;

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    #2;
    reset = 1'b0;  // released just after an edge
  end

endmodule

`default_nettype wire

// File: tb/tbMixRound.sv
`timescale 1ns/1ps
`default_nettype none

module tbMixRound;

  localparam int  numRandom   = 200;
  localparam int  numTests    = numRandom + 5;  // 2 known, 2 round trip, 1 busy start
  localparam int  resetCycles = 5;
  localparam int  latency     = 5;              // cycles from accepting edge to done
  localparam time driveDelay  = 2;

  logic                             clk;
  logic                             reset;
  logic                             start;
  aesMixPkg::mixRequest_t           request;
  logic                             busy;
  logic                             done;
  logic [aesMixPkg::stateWidth-1:0] result;
  int                               errorCount;

  tbClockGen i_tbClockGen (
    .clk   (clk),
    .reset (reset)
  );

  mixRound i_mixRound (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .request (request),
    .busy    (busy),
    .done    (done),
    .result  (result)
  );

  // ====================================================================
  // reference model
  // ====================================================================

  // shift and add multiply in GF(2^8)
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] acc;
    logic [7:0] p;
    acc = 8'h00;
    p   = a;
    for (int k = 0; k < 8; k++) begin
      if (b[k]) begin
        acc = acc ^ p;
      end
      p = aesMixPkg::xtime(p);
    end
    return acc;
  endfunction

  function automatic logic [31:0] mixColumnModel(input logic [31:0] col, input logic inverse);
    logic [7:0] coef [4];
    logic [7:0] inB  [4];
    logic [7:0] outB [4];
    if (inverse) begin
      coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    end else begin
      coef = '{8'h02, 8'h03, 8'h01, 8'h01};
    end
    for (int r = 0; r < 4; r++) begin
      inB[r] = col[31 - 8*r -: 8];  // byte 0 on top
    end
    for (int r = 0; r < 4; r++) begin
      outB[r] = 8'h00;
      for (int c = 0; c < 4; c++) begin
        outB[r] = outB[r] ^ gfMul(inB[c], coef[(c - r + 4) % 4]);  // circulant row
      end
    end
    return {outB[0], outB[1], outB[2], outB[3]};
  endfunction

  function automatic logic [127:0] modelRound(input aesMixPkg::mixRequest_t req);
    logic         inverse;
    logic [127:0] s;
    logic [127:0] mixedAll;
    inverse = (req.dir == aesMixPkg::mixInverse);
    s = inverse ? (req.state ^ req.roundKey) : req.state;  // inverse cipher keys first
    for (int c = 0; c < 4; c++) begin
      mixedAll[127 - 32*c -: 32] = mixColumnModel(s[127 - 32*c -: 32], inverse);
    end
    return inverse ? mixedAll : (mixedAll ^ req.roundKey);
  endfunction

  // ====================================================================
  // helpers
  // ====================================================================
  function automatic aesMixPkg::mixRequest_t makeRequest(input logic inverse,
                                                         input logic [127:0] st,
                                                         input logic [127:0] key);
    aesMixPkg::mixRequest_t req;
    req.dir      = inverse ? aesMixPkg::mixInverse : aesMixPkg::mixForward;
    req.state    = st;
    req.roundKey = key;
    return req;
  endfunction

  function automatic logic [127:0] randomBlock();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic checkValue(input string name, input logic [127:0] actual,
                            input logic [127:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
    end
  endtask

  // one request from start pulse to done, then the pulse must drop
  task automatic runRequest(input aesMixPkg::mixRequest_t req, input logic [127:0] expected);
    int cycles;
    @(posedge clk);
    #driveDelay;
    request = req;
    start   = 1'b1;
    @(posedge clk);  // accepting edge
    #driveDelay;
    start  = 1'b0;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (!done) begin
        checkValue("busy", 128'(busy), 128'd1);
      end
    end while (!done);
    checkValue("done latency", 128'(cycles), 128'(latency));
    checkValue("busy", 128'(busy), 128'd0);
    checkValue("result", result, expected);
    @(negedge clk);
    checkValue("done", 128'(done), 128'd0);
  endtask

  task automatic startWhileBusy(input aesMixPkg::mixRequest_t first,
                                input aesMixPkg::mixRequest_t second);
    logic [127:0] expected;
    int           cycles;
    int           doneCount;
    expected = modelRound(first);
    @(posedge clk);
    #driveDelay;
    request = first;
    start   = 1'b1;
    @(posedge clk);  // first accepted here
    #driveDelay;
    start = 1'b0;
    @(posedge clk);
    #driveDelay;
    request = second;
    start   = 1'b1;  // lands while busy
    @(posedge clk);
    #driveDelay;
    start  = 1'b0;
    cycles = 2;
    do begin
      @(negedge clk);
      cycles++;
    end while (!done);
    checkValue("done latency", 128'(cycles), 128'(latency));
    checkValue("result", result, expected);
    doneCount = 0;
    repeat (2 * latency) begin
      @(negedge clk);
      if (done) begin
        doneCount++;
      end
    end
    checkValue("extra done count", 128'(doneCount), 128'd0);
  endtask

  // ====================================================================
  // stimulus
  // ====================================================================
  initial begin
    aesMixPkg::mixRequest_t req;
    logic [127:0]           tripState;
    logic [127:0]           tripKey;
    logic [127:0]           fwdResult;
    start      = 1'b0;
    request    = '0;
    errorCount = 0;
    void'($urandom(51));

    @(posedge clk);
    wait (reset == 1'b0);
    @(negedge clk);
    checkValue("busy after reset", 128'(busy), 128'd0);
    checkValue("done after reset", 128'(done), 128'd0);
    checkValue("result after reset", result, 128'd0);

    // FIPS-197 column repeated in all four slots
    runRequest(makeRequest(1'b0, {4{32'hd4bf5d30}}, '0), {4{32'h046681e5}});
    runRequest(makeRequest(1'b1, {4{32'h046681e5}}, '0), {4{32'hd4bf5d30}});

    repeat (numRandom) begin
      req = makeRequest($urandom_range(1, 0) == 1, randomBlock(), randomBlock());
      runRequest(req, modelRound(req));
    end

    // forward then inverse with the same key
    tripState = randomBlock();
    tripKey   = randomBlock();
    req       = makeRequest(1'b0, tripState, tripKey);
    runRequest(req, modelRound(req));
    fwdResult = result;
    runRequest(makeRequest(1'b1, fwdResult, tripKey), tripState);

    startWhileBusy(makeRequest(1'b0, randomBlock(), randomBlock()),
                   makeRequest(1'b1, randomBlock(), randomBlock()));

    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (numTests * 10 + resetCycles) @(posedge clk);
    $display("Timeout: done never arrived within the expected number of cycles");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: mixRound.f
hdl/aesMixPkg.sv
hdl/mixColumnHelper.sv
hdl/columnSequencer.sv
hdl/mixRound.sv
tb/tbClockGen.sv
tb/tbMixRound.sv

// File: runSim.sh
#!/usr/bin/env bash
# build and run the mixRound testbench with Verilator
set -e

cd "$(dirname "$0")"

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert \
  --top-module tbMixRound \
  -f mixRound.f \
  --Mdir "$buildDir" \
  -o simMixRound

"$buildDir/simMixRound" > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "Simulation failed" "$logFile"; then
  echo "FAIL"
  exit 1
fi

if ! grep -q "Simulation completed successfully" "$logFile"; then
  echo "FAIL: run ended without a result"
  exit 1
fi

echo "PASS"
